// File: source/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen     = 32;
    localparam int mem_bits = 10;

    localparam logic [mem_bits-1:0] reset_pc = 128;

    // pointer reset values sized from the memory
    localparam logic [xlen-1:0] sp_reset = xlen'(2) << (mem_bits - 2);
    localparam logic [xlen-1:0] hp_reset = xlen'(1) << (mem_bits - 2);

    localparam logic [4:0] reg_sp = 5'd2;
    localparam logic [4:0] reg_gp = 5'd3;
    localparam logic [4:0] reg_hp = 5'd5;
    localparam logic [4:0] reg_a0 = 5'd10;

    // instr[6:2]
    typedef enum logic [4:0] {
        op_load      = 5'h00,
        op_rx        = 5'h02,
        op_arith_imm = 5'h04,
        op_auipc     = 5'h05,
        op_tx        = 5'h06,
        op_store     = 5'h08,
        op_arith     = 5'h0c,
        op_lui       = 5'h0d,
        op_branch    = 5'h18,
        op_jalr      = 5'h19,
        op_jal       = 5'h1b
    } opcode_t;

    typedef enum logic [4:0] {
        s_init, s_nextpc, s_fetch, s_decode, s_memaddr, s_memread, s_writeback,
        s_memwrite, s_transmit, s_arimm_exec, s_ari_exec, s_lui_read, s_auipc_read,
        s_alu_wb, s_compare, s_branch, s_link_rd, s_jump, s_recv_wait, s_recv_wb,
        s_halt
    } state_t;

    // same encoding as funct3
    typedef enum logic [2:0] {
        alu_add_sub = 3'b000,
        alu_shift_l = 3'b001,
        alu_lt      = 3'b010,
        alu_lt_u    = 3'b011,
        alu_xor     = 3'b100,
        alu_shift_r = 3'b101,
        alu_or      = 3'b110,
        alu_and     = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {srca_pc, srca_reg, srca_zero} src_a_t;

    typedef enum logic [2:0] {
        srcb_reg, srcb_four, srcb_imm_i, srcb_imm_s,
        srcb_imm_u, srcb_imm_b, srcb_imm_j, srcb_none
    } src_b_t;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_rx} wb_sel_t;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_t;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    input  cpu_pkg::alu_op_t         op,
    input  logic                     sub_sra,
    output logic [cpu_pkg::xlen-1:0] result,
    output logic                     zero
);
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            cpu_pkg::alu_add_sub: result = sub_sra ? a - b : a + b;
            cpu_pkg::alu_shift_l: result = a << shamt;
            cpu_pkg::alu_lt:      result = {{(cpu_pkg::xlen-1){1'b0}}, lt_s};
            cpu_pkg::alu_lt_u:    result = {{(cpu_pkg::xlen-1){1'b0}}, lt_u};
            cpu_pkg::alu_xor:     result = a ^ b;
            cpu_pkg::alu_shift_r: begin
                if (sub_sra) begin
                    result = $signed(a) >>> shamt; // sra
                end else begin
                    result = a >> shamt;
                end
            end
            cpu_pkg::alu_or:      result = a | b;
            default:              result = a & b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: source/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  cpu_pkg::instr_t          instr,
    input  cpu_pkg::src_b_t          sel,
    output logic [cpu_pkg::xlen-1:0] imm
);
    always_comb begin
        case (sel)
            cpu_pkg::srcb_imm_i:
                imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            cpu_pkg::srcb_imm_s:
                imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
            cpu_pkg::srcb_imm_u:
                imm = {instr.u_fmt.imm_31_12, 12'b0};
            cpu_pkg::srcb_imm_b:
                imm = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            cpu_pkg::srcb_imm_j:
                imm = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            default:
                imm = '0; // reg, four, none
        endcase
    end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic                     we,
    input  logic [cpu_pkg::xlen-1:0] wdata,
    output logic [cpu_pkg::xlen-1:0] rs1_data,
    output logic [cpu_pkg::xlen-1:0] rs2_data,
    output logic [7:0]               a0
);
    logic [cpu_pkg::xlen-1:0] regs [1:31]; // x0 not stored

    always_ff @(posedge clk) begin
        if (!rstn) begin
            regs[cpu_pkg::reg_sp] <= cpu_pkg::sp_reset;
            regs[cpu_pkg::reg_gp] <= '0;
            regs[cpu_pkg::reg_hp] <= cpu_pkg::hp_reset;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    assign a0 = regs[cpu_pkg::reg_a0][7:0];

endmodule

// File: source/main_controller.sv
`timescale 1ns/1ps

module main_controller (
    input  logic              clk,
    input  logic              rstn,
    input  cpu_pkg::instr_t   instr,
    input  logic              alu_zero,
    input  logic              rx_ready,
    output logic              pc_write,
    output logic              mem_write,
    output logic              reg_write,
    output cpu_pkg::src_a_t   alu_src_a,
    output cpu_pkg::src_b_t   alu_src_b,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              sub_sra,
    output cpu_pkg::wb_sel_t  wb_sel,
    output logic              tx_ready,
    output logic              next
);
    cpu_pkg::state_t  state;
    cpu_pkg::opcode_t opcode;
    cpu_pkg::src_b_t  imm_sel;
    logic [2:0]       funct3;
    logic [4:0]       rd;
    logic             alt;      // instr[30]
    logic             take;

    assign opcode = cpu_pkg::opcode_t'(instr.r_fmt.opcode[6:2]);
    assign funct3 = instr.r_fmt.funct3;
    assign rd     = instr.r_fmt.rd;
    assign alt    = instr.r_fmt.funct7[5];

    always_comb begin
        case (opcode)
            cpu_pkg::op_load,
            cpu_pkg::op_arith_imm,
            cpu_pkg::op_jalr:   imm_sel = cpu_pkg::srcb_imm_i;
            cpu_pkg::op_store:  imm_sel = cpu_pkg::srcb_imm_s;
            cpu_pkg::op_lui,
            cpu_pkg::op_auipc:  imm_sel = cpu_pkg::srcb_imm_u;
            cpu_pkg::op_branch: imm_sel = cpu_pkg::srcb_imm_b;
            cpu_pkg::op_jal:    imm_sel = cpu_pkg::srcb_imm_j;
            default:            imm_sel = cpu_pkg::srcb_none;
        endcase
    end

    // eq/ne use subtract, the rest less-than; funct3[0] inverts
    assign take = alu_zero ^ funct3[0] ^ (alu_op != cpu_pkg::alu_add_sub);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= cpu_pkg::s_init;
            pc_write  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
            alu_src_a <= cpu_pkg::srca_pc;
            alu_src_b <= cpu_pkg::srcb_four;
            alu_op    <= cpu_pkg::alu_add_sub;
            sub_sra   <= 1'b0;
            wb_sel    <= cpu_pkg::wb_alu;
            tx_ready  <= 1'b0;
            next      <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::s_writeback, cpu_pkg::s_memwrite, cpu_pkg::s_transmit,
                cpu_pkg::s_alu_wb, cpu_pkg::s_recv_wb: begin
                    state     <= cpu_pkg::s_nextpc;
                    pc_write  <= 1'b1;           // pc + 4
                    alu_src_a <= cpu_pkg::srca_pc;
                    alu_src_b <= cpu_pkg::srcb_four;
                    alu_op    <= cpu_pkg::alu_add_sub;
                    sub_sra   <= 1'b0;
                    reg_write <= 1'b0;
                    mem_write <= 1'b0;
                    tx_ready  <= 1'b0;
                end
                cpu_pkg::s_init, cpu_pkg::s_nextpc, cpu_pkg::s_branch,
                cpu_pkg::s_jump: begin
                    state     <= cpu_pkg::s_fetch;
                    pc_write  <= 1'b0;
                    reg_write <= 1'b0;           // link write ends here
                end
                cpu_pkg::s_fetch: state <= cpu_pkg::s_decode;
                cpu_pkg::s_decode: begin
                    alu_src_a <= cpu_pkg::srca_reg;
                    alu_src_b <= imm_sel;
                    alu_op    <= cpu_pkg::alu_add_sub;
                    sub_sra   <= 1'b0;
                    if (instr == '0) begin
                        state <= cpu_pkg::s_halt;
                    end else begin
                        case (opcode)
                            cpu_pkg::op_load, cpu_pkg::op_store:
                                state <= cpu_pkg::s_memaddr;
                            cpu_pkg::op_rx: begin
                                state <= cpu_pkg::s_recv_wait;
                                next  <= 1'b1;
                            end
                            cpu_pkg::op_tx: begin
                                state    <= cpu_pkg::s_transmit;
                                tx_ready <= 1'b1;
                            end
                            cpu_pkg::op_arith_imm: begin
                                state   <= cpu_pkg::s_arimm_exec;
                                alu_op  <= cpu_pkg::alu_op_t'(funct3);
                                sub_sra <= alt && funct3 == cpu_pkg::alu_shift_r; // srai only
                            end
                            cpu_pkg::op_arith: begin
                                state     <= cpu_pkg::s_ari_exec;
                                alu_src_b <= cpu_pkg::srcb_reg;
                                alu_op    <= cpu_pkg::alu_op_t'(funct3);
                                sub_sra   <= alt;
                            end
                            cpu_pkg::op_branch: begin
                                state     <= cpu_pkg::s_compare;
                                alu_src_b <= cpu_pkg::srcb_reg;
                                alu_op    <= cpu_pkg::alu_op_t'({1'b0, funct3[2:1]});
                                sub_sra   <= 1'b1;
                            end
                            cpu_pkg::op_lui: begin
                                state     <= cpu_pkg::s_lui_read;
                                alu_src_a <= cpu_pkg::srca_zero;
                            end
                            cpu_pkg::op_auipc: begin
                                state     <= cpu_pkg::s_auipc_read;
                                alu_src_a <= cpu_pkg::srca_pc;
                            end
                            cpu_pkg::op_jal, cpu_pkg::op_jalr: begin
                                state     <= cpu_pkg::s_link_rd;
                                alu_src_a <= cpu_pkg::srca_pc; // link = pc + 4
                                alu_src_b <= cpu_pkg::srcb_four;
                            end
                            default: state <= cpu_pkg::s_halt;
                        endcase
                    end
                end
                cpu_pkg::s_memaddr: begin
                    if (opcode == cpu_pkg::op_load) begin
                        state <= cpu_pkg::s_memread;
                    end else begin
                        state     <= cpu_pkg::s_memwrite;
                        mem_write <= 1'b1;
                    end
                end
                cpu_pkg::s_memread: begin
                    state     <= cpu_pkg::s_writeback;
                    wb_sel    <= cpu_pkg::wb_mem;
                    reg_write <= 1'b1;
                end
                cpu_pkg::s_arimm_exec, cpu_pkg::s_ari_exec, cpu_pkg::s_lui_read,
                cpu_pkg::s_auipc_read: begin
                    state     <= cpu_pkg::s_alu_wb;
                    wb_sel    <= cpu_pkg::wb_alu;
                    reg_write <= 1'b1;
                end
                cpu_pkg::s_compare: begin
                    state     <= cpu_pkg::s_branch;
                    alu_src_a <= cpu_pkg::srca_pc;
                    alu_src_b <= take ? imm_sel : cpu_pkg::srcb_four;
                    alu_op    <= cpu_pkg::alu_add_sub;
                    sub_sra   <= 1'b0;
                    pc_write  <= 1'b1;
                end
                cpu_pkg::s_link_rd: begin
                    state     <= cpu_pkg::s_jump;
                    alu_src_a <= (opcode == cpu_pkg::op_jal) ? cpu_pkg::srca_pc
                                                            : cpu_pkg::srca_reg;
                    alu_src_b <= imm_sel;
                    wb_sel    <= cpu_pkg::wb_alu;
                    reg_write <= (rd != 5'd0);
                    pc_write  <= 1'b1;
                end
                cpu_pkg::s_recv_wait: begin
                    if (rx_ready) begin
                        state     <= cpu_pkg::s_recv_wb;
                        next      <= 1'b0;
                        wb_sel    <= cpu_pkg::wb_rx;
                        reg_write <= 1'b1;
                    end
                end
                cpu_pkg::s_halt: state <= cpu_pkg::s_halt;
                default:         state <= cpu_pkg::s_halt;
            endcase
        end
    end

endmodule

// File: source/core.sv
`timescale 1ns/1ps

module core (
    input  logic                         clk,
    input  logic                         rstn,
    input  cpu_pkg::instr_t              instr,
    input  logic [cpu_pkg::xlen-1:0]     mem_dout,
    input  logic [7:0]                   rdata,
    input  logic                         rx_ready,
    output logic [cpu_pkg::mem_bits-3:0] pc_addr,
    output logic [cpu_pkg::mem_bits-3:0] mem_addr,
    output logic [cpu_pkg::xlen-1:0]     mem_din,
    output logic                         mem_we,
    output logic [7:0]                   sdata,
    output logic                         tx_ready,
    output logic                         next,
    output logic [7:0]                   a0_out
);
    logic [cpu_pkg::mem_bits-1:0] pc;
    logic [cpu_pkg::xlen-1:0]     a, b, alu_out;
    logic [7:0]                   rx_data;

    logic [cpu_pkg::xlen-1:0]     src_a, src_b, alu_result, imm, wdata;
    logic [cpu_pkg::xlen-1:0]     rs1_data, rs2_data;
    logic                         alu_zero;

    logic              pc_write, mem_write, reg_write, sub_sra;
    cpu_pkg::src_a_t   alu_src_a;
    cpu_pkg::src_b_t   alu_src_b;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::wb_sel_t  wb_sel;

    main_controller i_ctrl (
        .clk(clk), .rstn(rstn), .instr(instr), .alu_zero(alu_zero), .rx_ready(rx_ready),
        .pc_write(pc_write), .mem_write(mem_write), .reg_write(reg_write),
        .alu_src_a(alu_src_a), .alu_src_b(alu_src_b), .alu_op(alu_op),
        .sub_sra(sub_sra), .wb_sel(wb_sel), .tx_ready(tx_ready), .next(next)
    );

    alu i_alu (
        .a(src_a), .b(src_b), .op(alu_op), .sub_sra(sub_sra),
        .result(alu_result), .zero(alu_zero)
    );

    imm_gen i_imm (.instr(instr), .sel(alu_src_b), .imm(imm));

    reg_file i_regs (
        .clk(clk), .rstn(rstn), .rs1(instr.r_fmt.rs1), .rs2(instr.r_fmt.rs2),
        .rd(instr.r_fmt.rd), .we(reg_write), .wdata(wdata),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .a0(a0_out)
    );

    always_comb begin
        case (alu_src_a)
            cpu_pkg::srca_pc:  src_a = {{(cpu_pkg::xlen-cpu_pkg::mem_bits){1'b0}}, pc};
            cpu_pkg::srca_reg: src_a = a;
            default:           src_a = '0;
        endcase
        case (alu_src_b)
            cpu_pkg::srcb_reg:  src_b = b;
            cpu_pkg::srcb_four: src_b = {{(cpu_pkg::xlen-3){1'b0}}, 3'd4};
            default:            src_b = imm; // zero for none
        endcase
        case (wb_sel)
            cpu_pkg::wb_mem: wdata = mem_dout;
            cpu_pkg::wb_rx:  wdata = {{(cpu_pkg::xlen-8){1'b0}}, rx_data};
            default:         wdata = alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= cpu_pkg::reset_pc;
        end else if (pc_write) begin
            pc <= alu_result[cpu_pkg::mem_bits-1:0];
        end
    end

    always_ff @(posedge clk) begin
        a       <= rs1_data;
        b       <= rs2_data;
        alu_out <= alu_result;
        if (next && rx_ready) begin
            rx_data <= rdata;    // byte taken as next drops
        end
    end

    assign pc_addr  = pc[cpu_pkg::mem_bits-1:2];
    assign mem_addr = alu_out[cpu_pkg::mem_bits-1:2];
    assign mem_din  = b;
    assign mem_we   = mem_write;
    assign sdata    = a[7:0];

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    localparam time half_period = 20ns; // 40 ns period

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

// File: bench/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    localparam int words         = 2 ** (cpu_pkg::mem_bits - 2);
    localparam int reset_cycles  = 5;
    localparam int settle_cycles = 20;
    localparam int step_count    = 100; // executed instructions over all programs
    localparam int prog_count    = 4;
    localparam int rx_count      = 3;
    localparam int max_rx_delay  = 7;
    localparam int watchdog_cycles = step_count * 8
        + prog_count * (reset_cycles + settle_cycles + 3) + rx_count * (max_rx_delay + 2);

    logic clk;
    logic rstn = 1'b0;
    logic rx_ready = 1'b0;
    logic [7:0] rdata = 8'd0;
    cpu_pkg::instr_t instr = '0;
    logic [cpu_pkg::xlen-1:0] mem_dout = '0;
    logic [cpu_pkg::mem_bits-3:0] pc_addr, mem_addr;
    logic [cpu_pkg::xlen-1:0] mem_din;
    logic mem_we, tx_ready, next;
    logic [7:0] sdata, a0_out;

    logic [31:0] mem [words];
    logic [31:0] image [words];
    logic load = 1'b0;

    logic [7:0]  exp_addr [64];
    logic [31:0] exp_data [64];
    logic [7:0]  exp_tx [8];
    int n_exp = 0;
    int wr_idx = 0;
    int tx_idx = 0;
    int rx_idx = 0;
    int rx_cnt = 0;
    int rx_delay = 0;
    int errors = 0;
    int pc_w;
    logic [11:0] slot = 12'h300; // data area
    logic [11:0] last_slot;
    logic [7:0] halt_word = 8'hff;
    logic halted = 1'b0;
    logic rst_q = 1'b1;
    logic rst_q2 = 1'b1;
    logic a0_check = 1'b0;
    logic [7:0] a0_exp = 8'd0;

    tb_clock i_clock (.clk(clk));

    core i_core (
        .clk(clk), .rstn(rstn), .instr(instr), .mem_dout(mem_dout), .rdata(rdata),
        .rx_ready(rx_ready), .pc_addr(pc_addr), .mem_addr(mem_addr), .mem_din(mem_din),
        .mem_we(mem_we), .sdata(sdata), .tx_ready(tx_ready), .next(next), .a0_out(a0_out)
    );

    // both ports read synchronously
    always @(posedge clk) begin
        if (load) begin
            mem <= image;
        end else if (mem_we) begin
            mem[mem_addr] <= mem_din;
        end
        instr    <= mem[pc_addr];
        mem_dout <= mem[mem_addr];
    end

    // serial receiver side
    always @(posedge clk) begin
        if (!rstn) begin
            rx_ready <= 1'b0;
            rx_cnt   <= 0;
            rx_delay <= $urandom % (max_rx_delay + 1);
            rdata    <= 8'($urandom);
        end else if (rx_ready && next) begin
            rx_ready        <= 1'b0;
            exp_tx[rx_idx]  <= rdata + 8'd1; // wraps mod 256
            rx_idx          <= rx_idx + 1;
            rx_cnt          <= 0;
            rx_delay        <= $urandom % (max_rx_delay + 1);
            rdata           <= 8'($urandom);
        end else if (next) begin
            if (rx_cnt >= rx_delay) begin
                rx_ready <= 1'b1;
            end else begin
                rx_cnt <= rx_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && mem_we) wr_idx <= wr_idx + 1;
        if (rstn && tx_ready) tx_idx <= tx_idx + 1;
        rst_q  <= rstn;
        rst_q2 <= rst_q;
        halted <= rstn && (halted || pc_addr == halt_word);
    end

    reset_idle: assert property (@(posedge clk) (!rst_q || !rst_q2) |->
            (!mem_we && !tx_ready && !next && pc_addr == cpu_pkg::reset_pc[9:2]))
        else begin
            $display("CHECK FAILED at %0t: outputs not idle around reset", $time);
            errors++;
        end

    store_value: assert property (@(posedge clk) disable iff (!rstn) mem_we |->
            (mem_addr == exp_addr[wr_idx] && mem_din == exp_data[wr_idx]))
        else begin
            $display("CHECK FAILED at %0t: store %0d wrote %h to %h", $time, wr_idx,
                     mem_din, mem_addr);
            errors++;
        end

    tx_value: assert property (@(posedge clk) disable iff (!rstn) tx_ready |->
            sdata == exp_tx[tx_idx])
        else begin
            $display("CHECK FAILED at %0t: transmitted %h", $time, sdata);
            errors++;
        end

    halt_stays: assert property (@(posedge clk) disable iff (!rstn) halted |->
            (pc_addr == halt_word && !mem_we && !tx_ready))
        else begin
            $display("CHECK FAILED at %0t: core active after halt", $time);
            errors++;
        end

    a0_value: assert property (@(posedge clk) (halted && a0_check) |-> a0_out == a0_exp)
        else begin
            $display("CHECK FAILED at %0t: a0 is %h", $time, a0_out);
            errors++;
        end

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23}; // sw rs2, imm(x0)
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        image[pc_w] = w;
        pc_w++;
    endtask

    task automatic halt_here();
        halt_word = 8'(pc_w);
        emit(32'h0);
    endtask

    task automatic store_expect(input logic [4:0] rs, input logic [31:0] val);
        emit(encode_s(slot, rs));
        exp_addr[n_exp] = slot[9:2];
        exp_data[n_exp] = val;
        n_exp++;
        last_slot = slot;
        slot += 12'd4;
    endtask

    // lui + addi with random fields
    task automatic load_random(input logic [4:0] rd, output logic [31:0] val);
        logic [19:0] u;
        logic [11:0] lo;
        u  = 20'($urandom);
        lo = 12'($urandom);
        emit({u, rd, 7'h37});
        emit(encode_i(lo, rd, 3'b000, rd, 7'h13));
        val = {u, 12'b0} + {{20{lo[11]}}, lo};
    endtask

    task automatic arith_step(input logic [6:0] f7, input logic [2:0] f3,
            input logic [31:0] val);
        emit(encode_r(f7, 5'd2, 5'd1, f3, 5'd3));
        store_expect(5'd3, val);
    endtask

    task automatic build_arith();
        logic [11:0] ia;
        logic [31:0] a, b, pcb;
        logic [19:0] u;
        logic [4:0]  sh;
        ia = 12'($urandom);
        a  = {{20{ia[11]}}, ia};
        emit(encode_i(ia, 5'd0, 3'b000, 5'd1, 7'h13));
        load_random(5'd2, b);
        arith_step(7'h00, 3'b000, a + b);
        arith_step(7'h20, 3'b000, a - b);
        arith_step(7'h00, 3'b001, a << b[4:0]);
        arith_step(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
        arith_step(7'h00, 3'b011, {31'b0, a < b});
        arith_step(7'h00, 3'b100, a ^ b);
        arith_step(7'h00, 3'b101, a >> b[4:0]);
        arith_step(7'h20, 3'b101, $signed(a) >>> b[4:0]);
        arith_step(7'h00, 3'b110, a | b);
        arith_step(7'h00, 3'b111, a & b);
        sh = 5'($urandom);
        emit(encode_i({7'b0, sh}, 5'd1, 3'b001, 5'd3, 7'h13)); // slli
        store_expect(5'd3, a << sh);
        emit(encode_i({7'b0100000, sh}, 5'd2, 3'b101, 5'd3, 7'h13)); // srai
        store_expect(5'd3, $signed(b) >>> sh);
        u = 20'($urandom);
        emit({u, 5'd3, 7'h37});
        store_expect(5'd3, {u, 12'b0});
        u   = 20'($urandom);
        pcb = 32'(pc_w * 4);
        emit({u, 5'd3, 7'h17});
        store_expect(5'd3, pcb + {u, 12'b0});
        halt_here();
    endtask

    task automatic build_load_store();
        logic [31:0] v;
        load_random(5'd1, v);
        store_expect(5'd1, v);
        emit(encode_i(last_slot, 5'd0, 3'b010, 5'd10, 7'h03)); // lw a0
        store_expect(5'd10, v);
        a0_exp   = v[7:0];
        a0_check = 1'b1;
        halt_here();
    endtask

    task automatic build_branch();
        logic [11:0] n;
        logic [31:0] link;
        n = 12'(3 + $urandom % 4);
        emit(encode_i(n, 5'd0, 3'b000, 5'd1, 7'h13));
        emit(encode_i(12'd0, 5'd0, 3'b000, 5'd2, 7'h13));
        emit(encode_i(12'd1, 5'd2, 3'b000, 5'd2, 7'h13));     // loop
        emit(encode_i(12'hfff, 5'd1, 3'b000, 5'd1, 7'h13));
        emit(encode_b(-13'sd8, 5'd0, 5'd1, 3'b001));          // bne
        emit(encode_b(13'd8, 5'd2, 5'd1, 3'b100));            // blt taken
        emit(encode_i(12'd100, 5'd2, 3'b000, 5'd2, 7'h13));
        emit(encode_b(13'd8, 5'd1, 5'd2, 3'b111));            // bgeu taken
        emit(encode_i(12'd100, 5'd2, 3'b000, 5'd2, 7'h13));
        store_expect(5'd2, {20'b0, n});
        link = 32'(pc_w * 4 + 4);
        emit(encode_j(21'd12, 5'd1));                         // call past halt
        store_expect(5'd1, link);
        halt_here();
        emit(encode_i(12'd0, 5'd1, 3'b000, 5'd0, 7'h67));    // return
    endtask

    task automatic build_serial();
        for (int i = 0; i < rx_count; i++) begin
            emit(encode_i(12'd0, 5'd0, 3'b000, 5'd10, 7'h0b));
            emit(encode_i(12'd1, 5'd10, 3'b000, 5'd10, 7'h13));
            emit(encode_i(12'd0, 5'd10, 3'b000, 5'd0, 7'h1b));
        end
        halt_here();
    endtask

    task automatic run_program(input int which);
        @(posedge clk);
        rstn <= 1'b0;
        @(posedge clk);
        foreach (image[i]) image[i] = '0;
        pc_w     = cpu_pkg::reset_pc / 4;
        a0_check = 1'b0;
        case (which)
            0:       build_arith();
            1:       build_load_store();
            2:       build_branch();
            default: build_serial();
        endcase
        load <= 1'b1;
        @(posedge clk);
        load <= 1'b0;
        repeat (reset_cycles - 2) @(posedge clk);
        rstn <= 1'b1;
        while (!halted) @(posedge clk);
        repeat (settle_cycles) @(posedge clk);
        assert (wr_idx == n_exp)
            else begin
                $display("program %0d made %0d stores, expected %0d", which, wr_idx, n_exp);
                errors++;
            end
    endtask

    initial begin
        void'($urandom(32'h4c2d));
        for (int p = 0; p < prog_count; p++) begin
            run_program(p);
        end
        assert (tx_idx == rx_count)
            else begin
                $display("saw %0d transmits, expected %0d", tx_idx, rx_count);
                errors++;
            end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: programs did not finish within %0d cycles", watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: src.f
source/cpu_pkg.sv
source/alu.sv
source/imm_gen.sv
source/reg_file.sv
source/main_controller.sv
source/core.sv
bench/tb_clock.sv
bench/core_tb.sv

// File: Makefile
TOP = core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module core
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
